//--- all.f
icache_pkg.sv
mem_rd_if.sv
icache_core.sv
icache_refill_shim.sv
mem_rd_arbiter.sv
icache_subsys_top.sv
tb_icache_subsys.sv

//--- icache_core.sv
`timescale 1ns/1ps
`default_nettype none

module icache_core (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                flush_i,
  input  logic                                en_i,
  input  logic                                fetch_req_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0]   fetch_addr_i,
  input  logic                                fill_vld_i,
  input  icache_pkg::icache_fill_t            fill_i,
  input  logic                                miss_ack_i,
  output logic                                fetch_ready_o,
  output logic                                fetch_valid_o,
  output logic [icache_pkg::INSTR_WIDTH-1:0]  fetch_instr_o,
  output logic                                miss_o,
  output logic                                miss_req_o,
  output icache_pkg::icache_miss_t            miss_o_data
);
  import icache_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL
  } state_e;

  state_e state_q, state_d;

  logic [ADDR_WIDTH-1:0] addr_q;
  logic                  nc_q;
  logic                  alloc_q;

  // Tag and line store
  logic [NUM_SETS-1:0]   valid_q;
  logic [TAG_WIDTH-1:0]  tag_mem  [NUM_SETS];
  logic [LINE_WIDTH-1:0] line_mem [NUM_SETS];

  logic [INDEX_WIDTH-1:0]                      index;
  logic [TAG_WIDTH-1:0]                        tag;
  logic [LINE_WIDTH-1:0]                       hit_line;
  logic                                        hit;
  logic [OFFSET_WIDTH-INSTR_OFFSET_WIDTH-1:0]  line_word;
  logic [BEAT_OFFSET_WIDTH-INSTR_OFFSET_WIDTH-1:0] beat_word;

  assign index     = addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
  assign tag       = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign hit_line  = line_mem[index];
  assign line_word = addr_q[OFFSET_WIDTH-1:INSTR_OFFSET_WIDTH];
  assign beat_word = addr_q[BEAT_OFFSET_WIDTH-1:INSTR_OFFSET_WIDTH];

  // A disabled cache never hits
  assign hit = en_i & valid_q[index] & (tag_mem[index] == tag);

  // Refills fetch the whole line, bypassed reads a single beat
  always_comb begin
    miss_o_data.nc = ~en_i;
    if (en_i) begin
      miss_o_data.paddr = {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    end else begin
      miss_o_data.paddr = {addr_q[ADDR_WIDTH-1:BEAT_OFFSET_WIDTH], {BEAT_OFFSET_WIDTH{1'b0}}};
    end
  end

  always_comb begin
    state_d       = state_q;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    miss_req_o    = 1'b0;
    case (state_q)
      ST_IDLE: begin
        fetch_ready_o = 1'b1;
        if (fetch_req_i) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (hit) begin
          fetch_valid_o = 1'b1;
          state_d       = ST_IDLE;
        end else begin
          miss_req_o = 1'b1;
          if (miss_ack_i) begin
            state_d = ST_REFILL;
          end
        end
      end
      ST_REFILL: begin
        if (fill_vld_i) begin
          fetch_valid_o = 1'b1;
          state_d       = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  assign miss_o = miss_req_o & miss_ack_i;

  // Bypassed data sits in beat 0 of the returned line
  always_comb begin
    fetch_instr_o = hit_line[line_word*INSTR_WIDTH +: INSTR_WIDTH];
    if (state_q == ST_REFILL) begin
      if (nc_q) begin
        fetch_instr_o = fill_i.data[beat_word*INSTR_WIDTH +: INSTR_WIDTH];
      end else begin
        fetch_instr_o = fill_i.data[line_word*INSTR_WIDTH +: INSTR_WIDTH];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      valid_q <= '0;
      nc_q    <= 1'b0;
      alloc_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (miss_o) begin
        nc_q    <= ~en_i;
        alloc_q <= en_i;
      end
      if (state_q == ST_REFILL && fill_vld_i && alloc_q) begin
        valid_q[index] <= 1'b1;
      end
      // Flush wins over a refill landing in the same cycle
      if (flush_i) begin
        valid_q <= '0;
        alloc_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_req_i && fetch_ready_o) begin
      addr_q <= fetch_addr_i;
    end
    if (state_q == ST_REFILL && fill_vld_i && alloc_q) begin
      tag_mem[index]  <= tag;
      line_mem[index] <= fill_i.data;
    end
  end

endmodule

`default_nettype wire

//--- icache_pkg.sv
`default_nettype none

package icache_pkg;

  // Bus and cache geometry
  localparam int ADDR_WIDTH     = 32;
  localparam int MEM_DATA_WIDTH = 64;
  localparam int LINE_WIDTH     = 128;
  localparam int LINE_WORDS     = LINE_WIDTH / MEM_DATA_WIDTH;
  localparam int NUM_SETS       = 16;
  localparam int INSTR_WIDTH    = 32;
  localparam int ID_WIDTH       = 1;

  // Address split of a fetch
  localparam int OFFSET_WIDTH       = $clog2(LINE_WIDTH / 8);
  localparam int INDEX_WIDTH        = $clog2(NUM_SETS);
  localparam int TAG_WIDTH          = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int BEAT_OFFSET_WIDTH  = $clog2(MEM_DATA_WIDTH / 8);
  localparam int INSTR_OFFSET_WIDTH = $clog2(INSTR_WIDTH / 8);

  // Burst length field, beats minus one
  localparam int BLEN_WIDTH = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

  // Transaction ids on the shared read bus
  localparam logic [ID_WIDTH-1:0] ICACHE_TID = 1'b0;
  localparam logic [ID_WIDTH-1:0] DBG_TID    = 1'b1;

  // Miss request from the cache to the refill shim
  // paddr is line aligned for a refill and beat aligned for an uncached read
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] paddr;
    logic                  nc;
  } icache_miss_t;

  // Returned line, beat 0 in the low bits
  typedef struct packed {
    logic [LINE_WIDTH-1:0] data;
  } icache_fill_t;

endpackage

`default_nettype wire

//--- icache_refill_shim.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill_shim (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     miss_req_i,
  input  icache_pkg::icache_miss_t miss_i,
  output logic                     miss_ack_o,
  output logic                     fill_vld_o,
  output icache_pkg::icache_fill_t fill_o,
  mem_rd_if.requester              bus
);
  import icache_pkg::*;

  logic                                       req_valid_d, req_valid_q;
  icache_miss_t                               req_data_d, req_data_q;
  logic                                       first_d, first_q;
  logic [LINE_WORDS-1:0][MEM_DATA_WIDTH-1:0]  rd_shift_d, rd_shift_q;
  logic                                       beat_vld;

  // Hold the request on the bus until it is granted
  assign req_valid_d = ~bus.gnt & (miss_req_i | req_valid_q);
  assign req_data_d  = miss_req_i ? miss_i : req_data_q;

  assign bus.req  = miss_req_i | req_valid_q;
  assign bus.addr = req_data_d.paddr;
  assign bus.blen = req_data_d.nc ? '0 : BLEN_WIDTH'(LINE_WORDS - 1);
  assign bus.id   = ICACHE_TID;

  // The cache expects the ack in the same cycle
  assign miss_ack_o = miss_req_i;

  assign beat_vld    = bus.valid & (bus.rid == ICACHE_TID);
  assign fill_vld_o  = beat_vld & bus.last;
  assign fill_o.data = rd_shift_d;

  // New beats enter at the top and move down toward beat 0
  always_comb begin
    first_d    = first_q;
    rd_shift_d = rd_shift_q;
    if (beat_vld) begin
      first_d    = bus.last;
      rd_shift_d = {bus.data, rd_shift_q[LINE_WORDS-1:1]};
      // Single beat transfer lands at offset 0
      if (first_q) begin
        rd_shift_d[0] = bus.data;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_valid_q <= 1'b0;
      first_q     <= 1'b1;
    end else begin
      req_valid_q <= req_valid_d;
      first_q     <= first_d;
    end
  end

  always_ff @(posedge clk_i) begin
    req_data_q <= req_data_d;
    rd_shift_q <= rd_shift_d;
  end

endmodule

`default_nettype wire

//--- icache_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_subsys_top (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  flush_i,
  input  logic                                  en_i,
  input  logic                                  fetch_req_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0]     fetch_addr_i,
  output logic                                  fetch_ready_o,
  output logic                                  fetch_valid_o,
  output logic [icache_pkg::INSTR_WIDTH-1:0]    fetch_instr_o,
  output logic                                  miss_o,
  input  logic                                  dbg_req_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0]     dbg_addr_i,
  output logic                                  dbg_gnt_o,
  output logic                                  dbg_valid_o,
  output logic [icache_pkg::MEM_DATA_WIDTH-1:0] dbg_data_o,
  output logic                                  mem_req_o,
  output logic [icache_pkg::ADDR_WIDTH-1:0]     mem_addr_o,
  output logic [icache_pkg::BLEN_WIDTH-1:0]     mem_blen_o,
  output logic [icache_pkg::ID_WIDTH-1:0]       mem_id_o,
  input  logic                                  mem_gnt_i,
  input  logic                                  mem_valid_i,
  input  logic [icache_pkg::MEM_DATA_WIDTH-1:0] mem_data_i,
  input  logic                                  mem_last_i,
  input  logic [icache_pkg::ID_WIDTH-1:0]       mem_rid_i
);
  import icache_pkg::*;

  logic         miss_req;
  logic         miss_ack;
  icache_miss_t miss_data;
  logic         fill_vld;
  icache_fill_t fill_data;

  mem_rd_if icache_bus ();
  mem_rd_if dbg_bus ();
  mem_rd_if mem_bus ();

  icache_core i_icache_core (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .en_i          (en_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fill_vld_i    (fill_vld),
    .fill_i        (fill_data),
    .miss_ack_i    (miss_ack),
    .fetch_ready_o (fetch_ready_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_instr_o (fetch_instr_o),
    .miss_o        (miss_o),
    .miss_req_o    (miss_req),
    .miss_o_data   (miss_data)
  );

  icache_refill_shim i_refill_shim (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .miss_req_i (miss_req),
    .miss_i     (miss_data),
    .miss_ack_o (miss_ack),
    .fill_vld_o (fill_vld),
    .fill_o     (fill_data),
    .bus        (icache_bus.requester)
  );

  mem_rd_arbiter #(
    .ID_A (ICACHE_TID),
    .ID_B (DBG_TID)
  ) i_mem_rd_arbiter (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_a    (icache_bus.arbiter),
    .req_b    (dbg_bus.arbiter),
    .out      (mem_bus.requester)
  );

  // Debug port reads one beat at a time
  assign dbg_bus.req  = dbg_req_i;
  assign dbg_bus.addr = dbg_addr_i;
  assign dbg_bus.blen = '0;
  assign dbg_bus.id   = DBG_TID;
  assign dbg_gnt_o    = dbg_bus.gnt;
  assign dbg_valid_o  = dbg_bus.valid;
  assign dbg_data_o   = dbg_bus.data;

  // External read bus
  assign mem_req_o     = mem_bus.req;
  assign mem_addr_o    = mem_bus.addr;
  assign mem_blen_o    = mem_bus.blen;
  assign mem_id_o      = mem_bus.id;
  assign mem_bus.gnt   = mem_gnt_i;
  assign mem_bus.valid = mem_valid_i;
  assign mem_bus.data  = mem_data_i;
  assign mem_bus.last  = mem_last_i;
  assign mem_bus.rid   = mem_rid_i;

endmodule

`default_nettype wire

//--- mem_rd_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_rd_arbiter #(
  parameter logic [icache_pkg::ID_WIDTH-1:0] ID_A = icache_pkg::ICACHE_TID,
  parameter logic [icache_pkg::ID_WIDTH-1:0] ID_B = icache_pkg::DBG_TID
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  mem_rd_if.arbiter   req_a,
  mem_rd_if.arbiter   req_b,
  mem_rd_if.requester out
);

  logic last_b_q;
  logic hold_q;
  logic hold_sel_b_q;
  logic sel_b;

  // A waiting request keeps its slot so the bus request stays stable
  always_comb begin
    if (hold_q) begin
      sel_b = hold_sel_b_q;
    end else if (req_a.req && req_b.req) begin
      sel_b = ~last_b_q;
    end else begin
      sel_b = req_b.req;
    end
  end

  assign out.req  = req_a.req | req_b.req;
  assign out.addr = sel_b ? req_b.addr : req_a.addr;
  assign out.blen = sel_b ? req_b.blen : req_a.blen;
  assign out.id   = sel_b ? req_b.id : req_a.id;

  assign req_a.gnt = out.gnt & req_a.req & ~sel_b;
  assign req_b.gnt = out.gnt & req_b.req & sel_b;

  // Beats go to both sides, valid only to the owner of rid
  assign req_a.data  = out.data;
  assign req_a.last  = out.last;
  assign req_a.rid   = out.rid;
  assign req_a.valid = out.valid & (out.rid == ID_A);
  assign req_b.data  = out.data;
  assign req_b.last  = out.last;
  assign req_b.rid   = out.rid;
  assign req_b.valid = out.valid & (out.rid == ID_B);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_b_q     <= 1'b0;
      hold_q       <= 1'b0;
      hold_sel_b_q <= 1'b0;
    end else begin
      hold_q       <= out.req & ~out.gnt;
      hold_sel_b_q <= sel_b;
      if (out.req && out.gnt) begin
        last_b_q <= sel_b;
      end
    end
  end

endmodule

`default_nettype wire

//--- mem_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_rd_if;
  import icache_pkg::*;

  // Request side, held until gnt
  logic                      req;
  logic [ADDR_WIDTH-1:0]     addr;
  logic [BLEN_WIDTH-1:0]     blen;
  logic [ID_WIDTH-1:0]       id;
  logic                      gnt;

  // Response side, no ready
  logic                      valid;
  logic [MEM_DATA_WIDTH-1:0] data;
  logic                      last;
  logic [ID_WIDTH-1:0]       rid;

  modport requester (
    output req, addr, blen, id,
    input  gnt, valid, data, last, rid
  );

  modport arbiter (
    input  req, addr, blen, id,
    output gnt, valid, data, last, rid
  );

endinterface

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_icache_subsys -Mdir obj_dir \
  -o sim_icache -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_icache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0

//--- tb_icache_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache_subsys;
  import icache_pkg::*;

  // About 20 bus transfers of well under 20 cycles each, with a wide margin
  localparam int MAX_CYCLES = 4000;

  logic                      clk_i        = 1'b0;
  logic                      arst_n_i     = 1'b1;
  logic                      flush_i      = 1'b0;
  logic                      en_i         = 1'b1;
  logic                      fetch_req_i  = 1'b0;
  logic [ADDR_WIDTH-1:0]     fetch_addr_i = '0;
  logic                      dbg_req_i    = 1'b0;
  logic [ADDR_WIDTH-1:0]     dbg_addr_i   = '0;
  logic                      mem_gnt_i    = 1'b0;
  logic                      mem_valid_i  = 1'b0;
  logic [MEM_DATA_WIDTH-1:0] mem_data_i   = '0;
  logic                      mem_last_i   = 1'b0;
  logic [ID_WIDTH-1:0]       mem_rid_i    = '0;

  logic                      fetch_ready_o;
  logic                      fetch_valid_o;
  logic [INSTR_WIDTH-1:0]    fetch_instr_o;
  logic                      miss_o;
  logic                      dbg_gnt_o;
  logic                      dbg_valid_o;
  logic [MEM_DATA_WIDTH-1:0] dbg_data_o;
  logic                      mem_req_o;
  logic [ADDR_WIDTH-1:0]     mem_addr_o;
  logic [BLEN_WIDTH-1:0]     mem_blen_o;
  logic [ID_WIDTH-1:0]       mem_id_o;

  // Grant seen at the last rising edge
  logic                  gnt_seen = 1'b0;
  logic [ADDR_WIDTH-1:0] gnt_addr = '0;
  logic [BLEN_WIDTH-1:0] gnt_blen = '0;
  logic [ID_WIDTH-1:0]   gnt_id   = '0;

  // Request left waiting at the last rising edge
  logic                  req_waiting = 1'b0;

  // Memory model burst state
  logic [15:0]           lfsr       = 16'd42;
  logic [1:0]            wait_cnt   = 2'd0;
  int                    beats_left = 0;
  int                    beat_idx   = 0;
  logic [ADDR_WIDTH-1:0] burst_addr = '0;
  logic [ID_WIDTH-1:0]   burst_id   = '0;

  int                    miss_cnt        = 0;
  int                    icache_gnt_cnt  = 0;
  int                    dbg_gnt_cnt     = 0;
  logic [ADDR_WIDTH-1:0] icache_gnt_addr = '0;
  logic [BLEN_WIDTH-1:0] icache_gnt_blen = '0;
  int                    cycle_cnt       = 0;
  int                    checks          = 0;
  int                    errors          = 0;

  icache_subsys_top DUT (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .en_i          (en_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_instr_o (fetch_instr_o),
    .miss_o        (miss_o),
    .dbg_req_i     (dbg_req_i),
    .dbg_addr_i    (dbg_addr_i),
    .dbg_gnt_o     (dbg_gnt_o),
    .dbg_valid_o   (dbg_valid_o),
    .dbg_data_o    (dbg_data_o),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_blen_o    (mem_blen_o),
    .mem_id_o      (mem_id_o),
    .mem_gnt_i     (mem_gnt_i),
    .mem_valid_i   (mem_valid_i),
    .mem_data_i    (mem_data_i),
    .mem_last_i    (mem_last_i),
    .mem_rid_i     (mem_rid_i)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Memory content of the word at a word aligned byte address
  function automatic logic [INSTR_WIDTH-1:0] mem_word(input logic [ADDR_WIDTH-1:0] addr);
    mem_word = {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [MEM_DATA_WIDTH-1:0] beat_data(input logic [ADDR_WIDTH-1:0] addr,
                                                           input int beat);
    logic [ADDR_WIDTH-1:0] a;
    a         = addr + 32'(beat * 8);
    beat_data = {mem_word(a + 32'd4), mem_word(a)};
  endfunction

  // Bus monitor samples the values settled before the edge
  always @(posedge clk_i) begin
    gnt_seen    <= arst_n_i & mem_req_o & mem_gnt_i;
    req_waiting <= arst_n_i & mem_req_o & ~mem_gnt_i;
    gnt_addr    <= mem_addr_o;
    gnt_blen    <= mem_blen_o;
    gnt_id      <= mem_id_o;
    // A waiting request keeps its address, length and id until granted
    if (arst_n_i && req_waiting) begin
      if (!mem_req_o || mem_addr_o !== gnt_addr || mem_blen_o !== gnt_blen ||
          mem_id_o !== gnt_id) begin
        report_error("the bus request changed before it was granted");
      end
    end
    if (arst_n_i && mem_req_o && mem_gnt_i) begin
      if (mem_id_o == ICACHE_TID) begin
        icache_gnt_cnt  <= icache_gnt_cnt + 1;
        icache_gnt_addr <= mem_addr_o;
        icache_gnt_blen <= mem_blen_o;
      end else begin
        dbg_gnt_cnt <= dbg_gnt_cnt + 1;
      end
    end
    if (miss_o) begin
      miss_cnt <= miss_cnt + 1;
    end
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  // Memory model serves one burst at a time and holds grant high while idle
  always @(negedge clk_i) begin
    mem_valid_i = 1'b0;
    mem_last_i  = 1'b0;
    if (!arst_n_i) begin
      beats_left = 0;
      mem_gnt_i  = 1'b0;
    end else begin
      if (gnt_seen) begin
        // Two LFSR bits give a response delay of 0 to 3 cycles
        for (int i = 0; i < 2; i++) begin
          wait_cnt = {wait_cnt[0], lfsr[0]};
          lfsr     = lfsr_next(lfsr);
        end
        beats_left = int'(gnt_blen) + 1;
        beat_idx   = 0;
        burst_addr = gnt_addr;
        burst_id   = gnt_id;
      end
      if (beats_left > 0) begin
        if (wait_cnt != 2'd0) begin
          wait_cnt = wait_cnt - 2'd1;
        end else begin
          mem_valid_i = 1'b1;
          mem_data_i  = beat_data(burst_addr, beat_idx);
          mem_rid_i   = burst_id;
          mem_last_i  = (beats_left == 1);
          beats_left  = beats_left - 1;
          beat_idx    = beat_idx + 1;
        end
      end
      mem_gnt_i = (beats_left == 0);
    end
  end

  task automatic report_error(input string msg);
    errors++;
    $display("Fail at %0d ns: %s", $time, msg);
  endtask

  task automatic check_instr(input logic [INSTR_WIDTH-1:0] got, input logic [INSTR_WIDTH-1:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_line_addr(input logic [ADDR_WIDTH-1:0] got,
                                 input logic [ADDR_WIDTH-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_blen(input logic [BLEN_WIDTH-1:0] got, input logic [BLEN_WIDTH-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("%s got %0d expected %0d", what, got, exp));
    end
  endtask

  task automatic expect_low(input logic value, input string name);
    checks++;
    if (value !== 1'b0) begin
      report_error({name, " is not low"});
    end
  endtask

  task automatic idle_outputs_low();
    expect_low(fetch_valid_o, "fetch_valid_o");
    expect_low(miss_o, "miss_o");
    expect_low(mem_req_o, "mem_req_o");
    expect_low(dbg_gnt_o, "dbg_gnt_o");
    expect_low(dbg_valid_o, "dbg_valid_o");
  endtask

  // One fetch from request to data, then the refill it caused
  task automatic fetch_word(input logic [ADDR_WIDTH-1:0] addr, input bit exp_miss,
                            input logic [BLEN_WIDTH-1:0] exp_blen);
    int                    misses_before;
    int                    gnts_before;
    int                    lat;
    logic [ADDR_WIDTH-1:0] exp_addr;
    misses_before = miss_cnt;
    gnts_before   = icache_gnt_cnt;
    @(negedge clk_i);
    fetch_req_i  = 1'b1;
    fetch_addr_i = addr;
    @(posedge clk_i);
    while (!fetch_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    fetch_req_i = 1'b0;
    lat = 1;
    @(posedge clk_i);
    while (!fetch_valid_o) begin
      @(posedge clk_i);
      lat++;
    end
    check_instr(fetch_instr_o, mem_word({addr[ADDR_WIDTH-1:2], 2'b00}), "fetch word");
    if (exp_miss) begin
      if (miss_cnt - misses_before != 1) begin
        report_error("expected exactly one miss_o pulse");
      end
      if (icache_gnt_cnt - gnts_before != 1) begin
        report_error("expected exactly one refill burst");
      end
      // Single beat reads are beat aligned, line refills line aligned
      if (exp_blen == '0) begin
        exp_addr = {addr[ADDR_WIDTH-1:3], 3'b000};
      end else begin
        exp_addr = {addr[ADDR_WIDTH-1:4], 4'b0000};
      end
      check_line_addr(icache_gnt_addr, exp_addr, "refill address");
      check_blen(icache_gnt_blen, exp_blen, "refill burst length");
    end else begin
      if (miss_cnt != misses_before || icache_gnt_cnt != gnts_before) begin
        report_error("a hit caused a miss or a bus request");
      end
      if (lat != 1) begin
        report_error($sformatf("hit data came %0d cycles after acceptance", lat));
      end
    end
  endtask

  task automatic debug_read(input logic [ADDR_WIDTH-1:0] addr);
    @(negedge clk_i);
    dbg_req_i  = 1'b1;
    dbg_addr_i = addr;
    @(posedge clk_i);
    while (!dbg_gnt_o) @(posedge clk_i);
    @(negedge clk_i);
    dbg_req_i = 1'b0;
    @(posedge clk_i);
    while (!dbg_valid_o) @(posedge clk_i);
    check_instr(dbg_data_o[INSTR_WIDTH-1:0], mem_word(addr), "debug low word");
    check_instr(dbg_data_o[MEM_DATA_WIDTH-1:INSTR_WIDTH], mem_word(addr + 32'd4),
                "debug high word");
  endtask

  task automatic reset_outputs();
    arst_n_i = 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      idle_outputs_low();
    end
    arst_n_i = 1'b1;
    @(negedge clk_i);
    idle_outputs_low();
    if (!fetch_ready_o) begin
      report_error("fetch_ready_o is low after reset");
    end
  endtask

  task automatic miss_then_hit();
    fetch_word(32'h0000_1004, 1'b1, BLEN_WIDTH'(LINE_WORDS - 1));
    fetch_word(32'h0000_100c, 1'b0, '0);
  endtask

  task automatic bypass_fetch();
    @(negedge clk_i);
    en_i = 1'b0;
    fetch_word(32'h0000_2014, 1'b1, '0);
    fetch_word(32'h0000_2014, 1'b1, '0);
    // Cached line is ignored while disabled
    fetch_word(32'h0000_1008, 1'b1, '0);
    @(negedge clk_i);
    en_i = 1'b1;
  endtask

  task automatic flush_refill();
    fetch_word(32'h0000_1004, 1'b0, '0);
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    fetch_word(32'h0000_1004, 1'b1, BLEN_WIDTH'(LINE_WORDS - 1));
    fetch_word(32'h0000_1000, 1'b0, '0);
  endtask

  task automatic shared_bus_reads();
    int dbg_before;
    dbg_before = dbg_gnt_cnt;
    fork
      begin
        fetch_word(32'h0000_3018, 1'b1, BLEN_WIDTH'(LINE_WORDS - 1));
        fetch_word(32'h0000_4124, 1'b1, BLEN_WIDTH'(LINE_WORDS - 1));
        fetch_word(32'h0000_503c, 1'b1, BLEN_WIDTH'(LINE_WORDS - 1));
        fetch_word(32'h0000_3010, 1'b0, '0);
      end
      begin
        debug_read(32'h0000_8000);
        debug_read(32'h0000_8008);
        debug_read(32'h0000_9010);
        debug_read(32'h0000_1000);
      end
    join
    if (dbg_gnt_cnt - dbg_before != 4) begin
      report_error("expected four debug grants on the memory bus");
    end
  endtask

  initial begin
    reset_outputs();
    miss_then_hit();
    bypass_fetch();
    flush_refill();
    shared_bus_reads();
    repeat (2) @(posedge clk_i);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
